// File: Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
FLIST     ?= exu_cluster.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard verilog/*.sv bench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/exu_chk.sv
`timescale 1ns/1ps

module exu_chk #(
    parameter int buf_depth  = 4,
    parameter int wb_credits = 2
) (
    input logic                             clk,
    input logic                             rst,
    input logic                             disp_credit,
    input logic                             iss_valid,
    input logic                             res_valid,
    input logic                             buf_credit,
    input logic                             sq_credit,
    input logic                             wb_valid,
    input logic                             wb_credit,
    input logic                             redirect_valid,
    input logic [$clog2(buf_depth + 1)-1:0] space_cnt
);
    // writeback credits as seen on the ports.
    int wb_avail;
    int assert_fails = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_avail <= wb_credits;
        end else begin
            wb_avail <= wb_avail - int'(wb_valid) + int'(wb_credit);
        end
    end

    //////////////////////////////////////////////////
    // credit and pulse rules
    //////////////////////////////////////////////////

    wb_needs_credit: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> (wb_avail > 0))
        else begin
            $error("wb_valid raised with no writeback credit");
            assert_fails = assert_fails + 1;
        end

    redirect_one_cycle: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !redirect_valid)
        else begin
            $error("redirect_valid held for two cycles");
            assert_fails = assert_fails + 1;
        end

    space_bounded: assert property (@(posedge clk) disable iff (rst)
        int'(space_cnt) <= buf_depth)
        else begin
            $error("issue queue space counter above buf_depth");
            assert_fails = assert_fails + 1;
        end

    // all handshakes quiet right after reset.
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !(disp_credit || iss_valid || res_valid || buf_credit
                  || sq_credit || wb_valid || redirect_valid))
        else begin
            $error("control output high right after reset");
            assert_fails = assert_fails + 1;
        end

endmodule

bind exu_top exu_chk #(
    .buf_depth  (buf_depth),
    .wb_credits (wb_credits)
) i_exu_chk (
    .clk            (clk),
    .rst            (rst),
    .disp_credit    (disp_credit),
    .iss_valid      (iss_valid),
    .res_valid      (res_valid),
    .buf_credit     (buf_credit),
    .sq_credit      (sq_credit),
    .wb_valid       (wb_valid),
    .wb_credit      (wb_credit),
    .redirect_valid (redirect_valid),
    .space_cnt      (i_issue_queue.space_cnt)
);

// File: bench/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

    localparam int iq_depth   = 4;
    localparam int buf_depth  = 4;
    localparam int wb_credits = 2;

    logic              clk;
    logic              rst;
    logic              disp_valid;
    exu_pkg::alu_op_t  disp_op;
    exu_pkg::data_t    disp_rs1;
    exu_pkg::data_t    disp_rs2;
    exu_pkg::rob_idx_t disp_rob;
    logic              disp_epoch;
    logic              disp_pred_taken;
    logic              disp_credit;
    logic              wb_valid;
    exu_pkg::rob_idx_t wb_rob;
    exu_pkg::data_t    wb_data;
    logic              wb_credit = 1'b0;
    logic              redirect_valid;
    exu_pkg::rob_idx_t redirect_rob;
    logic              redirect_taken;

    // trace columns.
    int t_test[$];
    int t_op[$];
    int t_rs1[$];
    int t_rs2[$];
    int t_rob[$];
    int t_epoch[$];
    int t_pred[$];
    int t_exp[$];
    int t_live[$];

    // expected writebacks and redirects.
    int   ew_rob[$];
    int   ew_data[$];
    int   ew_test[$];
    int   er_rob[$];
    logic er_taken[$];

    int          dispatched;
    int          credit_pulses;
    int          wb_seen;
    int          redir_seen;
    int          credits_returned;
    int          test_results;
    int          errors;
    int          misc_errors;
    int          cycle;
    int          cycle_limit = 1000;
    int          gap;
    logic [31:0] rng_state = 32'hfcfe;

    exu_top #(
        .iq_depth   (iq_depth),
        .buf_depth  (buf_depth),
        .wb_credits (wb_credits)
    ) i_exu_top (
        .clk             (clk),
        .rst             (rst),
        .disp_valid      (disp_valid),
        .disp_op         (disp_op),
        .disp_rs1        (disp_rs1),
        .disp_rs2        (disp_rs2),
        .disp_rob        (disp_rob),
        .disp_epoch      (disp_epoch),
        .disp_pred_taken (disp_pred_taken),
        .disp_credit     (disp_credit),
        .wb_valid        (wb_valid),
        .wb_rob          (wb_rob),
        .wb_data         (wb_data),
        .wb_credit       (wb_credit),
        .redirect_valid  (redirect_valid),
        .redirect_rob    (redirect_rob),
        .redirect_taken  (redirect_taken)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic compare_data(input string name, input exu_pkg::data_t got,
                                input exu_pkg::data_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_rob(input string name, input exu_pkg::rob_idx_t got,
                               input exu_pkg::rob_idx_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_redirect(input exu_pkg::rob_idx_t got_rob, input logic got_taken,
                                    input exu_pkg::rob_idx_t exp_rob, input logic exp_taken);
        compare_rob("redirect_rob", got_rob, exp_rob);
        if (got_taken !== exp_taken) begin
            $display("error at %0t: redirect_taken got %b expected %b",
                     $time, got_taken, exp_taken);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // trace and expected results
    //////////////////////////////////////////////////

    task automatic read_trace();
        int    fd;
        int    cnt;
        int    f_test, f_op, f_rs1, f_rs2, f_rob, f_epoch, f_pred, f_exp, f_live;
        string line;
        fd = $fopen("bench/exu_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/exu_trace.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%d %d %h %h %h %d %d %h %d", f_test, f_op, f_rs1, f_rs2,
                          f_rob, f_epoch, f_pred, f_exp, f_live);
            if (cnt == 9) begin
                t_test.push_back(f_test);
                t_op.push_back(f_op);
                t_rs1.push_back(f_rs1);
                t_rs2.push_back(f_rs2);
                t_rob.push_back(f_rob);
                t_epoch.push_back(f_epoch);
                t_pred.push_back(f_pred);
                t_exp.push_back(f_exp);
                t_live.push_back(f_live);
            end else if (cnt > 0) begin
                $display("malformed trace line: %s", line);
                misc_errors++;
            end
        end
        $fclose(fd);
    endtask

    // epoch walk, a mispredicted live branch flips it.
    task automatic build_expected();
        logic cur_epoch;
        logic live;
        logic taken;
        logic branch;
        int   i;
        cur_epoch = 1'b0;
        for (i = 0; i < t_op.size(); i++) begin
            live   = (1'(t_epoch[i]) == cur_epoch);
            taken  = (t_exp[i] != 0);
            branch = (t_op[i] == int'(exu_pkg::op_beq)) || (t_op[i] == int'(exu_pkg::op_bne))
                   || (t_op[i] == int'(exu_pkg::op_blt));
            if (live != (t_live[i] != 0)) begin
                $display("trace line %0d: live flag disagrees with the epoch walk", i + 1);
                misc_errors++;
            end
            if (t_live[i] != 0) begin
                ew_rob.push_back(t_rob[i]);
                ew_data.push_back(t_exp[i]);
                ew_test.push_back(t_test[i]);
            end
            if (live && branch && (taken != 1'(t_pred[i]))) begin
                cur_epoch = ~cur_epoch;
                er_rob.push_back(t_rob[i]);
                er_taken.push_back(taken);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        rst             = 1'b1;
        disp_valid      = 1'b0;
        disp_op         = exu_pkg::op_add;
        disp_rs1        = '0;
        disp_rs2        = '0;
        disp_rob        = '0;
        disp_epoch      = 1'b0;
        disp_pred_taken = 1'b0;
        read_trace();
        build_expected();
        if (t_op.size() == 0) begin
            $display("the trace holds no operations");
            misc_errors++;
        end
        cycle_limit = 40 * t_op.size() + 200;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // dispatch only while a credit is held.
        while (dispatched < t_op.size()) begin
            @(posedge clk);
            if (iq_depth + credit_pulses - dispatched > 0) begin
                disp_valid      <= 1'b1;
                disp_op         <= exu_pkg::alu_op_t'(4'(t_op[dispatched]));
                disp_rs1        <= exu_pkg::data_t'(t_rs1[dispatched]);
                disp_rs2        <= exu_pkg::data_t'(t_rs2[dispatched]);
                disp_rob        <= exu_pkg::rob_idx_t'(t_rob[dispatched]);
                disp_epoch      <= 1'(t_epoch[dispatched]);
                disp_pred_taken <= 1'(t_pred[dispatched]);
                dispatched++;
            end else begin
                disp_valid <= 1'b0;
            end
        end
        @(posedge clk);
        disp_valid <= 1'b0;

        while (wb_seen < ew_rob.size() || credit_pulses < dispatched) begin
            @(posedge clk);
        end
        // room for stray writebacks or redirects.
        repeat (20) @(posedge clk);

        if (redir_seen != er_rob.size()) begin
            $display("error at %0t: redirect count got %0d expected %0d",
                     $time, redir_seen, er_rob.size());
            misc_errors++;
        end
        if (credit_pulses != dispatched) begin
            $display("error at %0t: disp_credit pulses got %0d expected %0d",
                     $time, credit_pulses, dispatched);
            misc_errors++;
        end
        if (i_exu_top.i_exu_chk.assert_fails != 0) begin
            $display("the bound checker saw %0d assertion failures",
                     i_exu_top.i_exu_chk.assert_fails);
            misc_errors = misc_errors + i_exu_top.i_exu_chk.assert_fails;
        end
        $display("summary: %0d ops, %0d writebacks, %0d redirects, %0d errors",
                 dispatched, wb_seen, redir_seen, errors + misc_errors);
        if (errors + misc_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    //////////////////////////////////////////////////
    // output monitor, sampled mid cycle
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            if (disp_credit) begin
                credit_pulses++;
            end
            if (wb_valid) begin
                if (wb_seen < ew_rob.size()) begin
                    compare_rob("wb_rob", wb_rob, exu_pkg::rob_idx_t'(ew_rob[wb_seen]));
                    compare_data("wb_data", wb_data, exu_pkg::data_t'(ew_data[wb_seen]));
                    test_results++;
                    if (wb_seen + 1 == ew_rob.size()
                            || ew_test[wb_seen + 1] != ew_test[wb_seen]) begin
                        $display("test %0d finished: %0d results, %0d errors so far",
                                 ew_test[wb_seen], test_results, errors);
                        test_results = 0;
                    end
                end else begin
                    $display("writeback of rob %h arrived after all expected results", wb_rob);
                    errors++;
                end
                wb_seen++;
            end
            if (redirect_valid) begin
                if (redir_seen < er_rob.size()) begin
                    compare_redirect(redirect_rob, redirect_taken,
                                     exu_pkg::rob_idx_t'(er_rob[redir_seen]),
                                     er_taken[redir_seen]);
                end else begin
                    $display("redirect for rob %h was not expected", redirect_rob);
                    errors++;
                end
                redir_seen++;
            end
        end
    end

    // writeback credits come back after random gaps.
    always @(posedge clk) begin
        if (rst) begin
            wb_credit <= 1'b0;
            gap       <= 0;
        end else if (wb_seen > credits_returned && gap == 0) begin
            wb_credit <= 1'b1;
            credits_returned = credits_returned + 1;
            rng_state = xorshift32(rng_state);
            gap <= int'(rng_state & 32'd7);
        end else begin
            wb_credit <= 1'b0;
            if (gap > 0) begin
                gap <= gap - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("timeout: run did not complete within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

endmodule

// File: bench/exu_trace.txt
# columns: test opcode rs1 rs2 rob epoch pred_taken exp_data exp_live
# opcode 0..10 is add sub and or xor sll srl slt beq bne blt; rs1 rs2 rob exp_data in hex
1 0 00000005 00000003 01 0 0 00000008 1
1 1 00000005 00000007 02 0 0 fffffffe 1
1 2 0000f0f0 00ff00ff 03 0 0 000000f0 1
1 3 0000f0f0 00ff00ff 04 0 0 00fff0ff 1
1 4 aaaa5555 ffff0000 05 0 0 55555555 1
1 5 00000001 00000024 06 0 0 00000010 1
1 6 80000000 0000001f 07 0 0 00000001 1
1 7 ffffffff 00000001 08 0 0 00000001 1
1 7 00000001 ffffffff 09 0 0 00000000 1
2 8 00000010 00000010 0a 0 1 00000001 1
2 9 00000010 00000010 0b 0 0 00000000 1
2 10 fffffff0 00000004 0c 0 1 00000001 1
2 8 00000001 00000002 0d 0 0 00000000 1
3 9 00000003 00000004 0e 0 0 00000001 1
3 0 00000001 00000001 0f 0 0 00000002 0
3 2 ffffffff 0000000f 10 0 0 0000000f 0
3 0 00000064 00000001 11 1 0 00000065 1
3 10 00000005 00000003 12 1 1 00000000 1
3 4 0000ffff 00000001 13 1 0 0000fffe 0
3 1 00000000 00000001 14 0 0 ffffffff 1
4 0 12345678 11111111 15 0 0 23456789 1
4 3 12340000 00005678 16 0 0 12345678 1
4 5 0000000f 00000008 17 0 0 00000f00 1
4 6 f0000000 00000004 18 0 0 0f000000 1
4 1 00000000 00000000 19 0 0 00000000 1
4 4 ffffffff 0f0f0f0f 1a 0 0 f0f0f0f0 1
5 0 00000001 00000001 1b 0 0 00000002 1
5 0 00000002 00000002 1c 0 0 00000004 1
5 0 00000004 00000004 1d 0 0 00000008 1
5 0 00000008 00000008 1e 0 0 00000010 1
5 5 00000003 00000002 1f 0 0 0000000c 1
5 6 00000100 00000003 20 0 0 00000020 1
5 2 ffff0000 0ff00ff0 21 0 0 0ff00000 1
5 7 7fffffff 80000000 22 0 0 00000000 1

// File: exu_cluster.f
verilog/exu_pkg.sv
verilog/issue_queue.sv
verilog/alu_unit.sv
verilog/result_buffer.sv
verilog/exu_top.sv
bench/exu_chk.sv
bench/exu_tb.sv

// File: verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              iss_valid,
    input  exu_pkg::alu_op_t  iss_op,
    input  exu_pkg::data_t    iss_rs1,
    input  exu_pkg::data_t    iss_rs2,
    input  exu_pkg::rob_idx_t iss_rob,
    input  logic              iss_epoch,
    input  logic              iss_pred_taken,
    output logic              res_valid,
    output exu_pkg::rob_idx_t res_rob,
    output exu_pkg::data_t    res_data,
    output logic              sq_credit,
    output logic              redirect_valid,
    output exu_pkg::rob_idx_t redirect_rob,
    output logic              redirect_taken
);
    logic              s1_valid;
    exu_pkg::alu_op_t  s1_op;
    exu_pkg::data_t    s1_rs1;
    exu_pkg::data_t    s1_rs2;
    exu_pkg::rob_idx_t s1_rob;
    logic              s1_epoch;
    logic              s1_pred_taken;

    logic                        epoch;
    logic                        s1_live;
    logic                        s1_taken;
    logic                        s1_mispredict;
    logic [exu_pkg::shamt_w-1:0] shamt;
    exu_pkg::data_t              s1_result;

    //////////////////////////////////////////////////
    // stage 1
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            s1_op         <= iss_op;
            s1_rs1        <= iss_rs1;
            s1_rs2        <= iss_rs2;
            s1_rob        <= iss_rob;
            s1_epoch      <= iss_epoch;
            s1_pred_taken <= iss_pred_taken;
        end
    end

    // stale epoch means it follows a mispredict.
    assign s1_live = s1_valid && (s1_epoch == epoch);
    assign shamt   = s1_rs2[exu_pkg::shamt_w-1:0];

    always_comb begin
        case (s1_op)
            exu_pkg::op_beq: s1_taken = (s1_rs1 == s1_rs2);
            exu_pkg::op_bne: s1_taken = (s1_rs1 != s1_rs2);
            exu_pkg::op_blt: s1_taken = ($signed(s1_rs1) < $signed(s1_rs2));
            default:         s1_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (s1_op)
            exu_pkg::op_add: s1_result = s1_rs1 + s1_rs2;
            exu_pkg::op_sub: s1_result = s1_rs1 - s1_rs2;
            exu_pkg::op_and: s1_result = s1_rs1 & s1_rs2;
            exu_pkg::op_or:  s1_result = s1_rs1 | s1_rs2;
            exu_pkg::op_xor: s1_result = s1_rs1 ^ s1_rs2;
            exu_pkg::op_sll: s1_result = s1_rs1 << shamt;
            exu_pkg::op_srl: s1_result = s1_rs1 >> shamt;
            exu_pkg::op_slt: s1_result = exu_pkg::data_t'($signed(s1_rs1) < $signed(s1_rs2));
            exu_pkg::op_beq,
            exu_pkg::op_bne,
            exu_pkg::op_blt: s1_result = exu_pkg::data_t'(s1_taken);
            default:         s1_result = '0;
        endcase
    end

    assign s1_mispredict = s1_live && exu_pkg::is_branch(s1_op)
                         && (s1_taken != s1_pred_taken);

    //////////////////////////////////////////////////
    // stage 2 and redirect
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid       <= 1'b0;
            epoch          <= 1'b0;
            res_valid      <= 1'b0;
            sq_credit      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            s1_valid       <= iss_valid;
            res_valid      <= s1_live;
            sq_credit      <= s1_valid && !s1_live;
            redirect_valid <= s1_mispredict;
            if (s1_mispredict) begin
                epoch <= ~epoch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_live) begin
            res_rob  <= s1_rob;
            res_data <= s1_result;
        end
        if (s1_mispredict) begin
            redirect_rob   <= s1_rob;
            redirect_taken <= s1_taken;
        end
    end

endmodule

// File: verilog/exu_pkg.sv
package exu_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    parameter int xlen = 32;

    // includes the wrap bit.
    parameter int rob_width = 6;

    parameter int shamt_w = $clog2(xlen);

    //////////////////////////////////////////////////
    // shared types
    //////////////////////////////////////////////////

    typedef logic [xlen-1:0] data_t;

    typedef logic [rob_width-1:0] rob_idx_t;

    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_sll = 4'd5,
        op_srl = 4'd6,
        op_slt = 4'd7,
        // branches resolve to 1 when taken.
        op_beq = 4'd8,
        op_bne = 4'd9,
        op_blt = 4'd10
    } alu_op_t;

    function automatic logic is_branch(input alu_op_t op);
        logic br;
        br = (op == op_beq) || (op == op_bne) || (op == op_blt);
        return br;
    endfunction

endpackage

// File: verilog/exu_top.sv
`timescale 1ns/1ps

module exu_top #(
    parameter int iq_depth   = 4,
    parameter int buf_depth  = 4,
    parameter int wb_credits = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              disp_valid,
    input  exu_pkg::alu_op_t  disp_op,
    input  exu_pkg::data_t    disp_rs1,
    input  exu_pkg::data_t    disp_rs2,
    input  exu_pkg::rob_idx_t disp_rob,
    input  logic              disp_epoch,
    input  logic              disp_pred_taken,
    output logic              disp_credit,
    output logic              wb_valid,
    output exu_pkg::rob_idx_t wb_rob,
    output exu_pkg::data_t    wb_data,
    input  logic              wb_credit,
    output logic              redirect_valid,
    output exu_pkg::rob_idx_t redirect_rob,
    output logic              redirect_taken
);
    // issue side.
    logic              iss_valid;
    exu_pkg::alu_op_t  iss_op;
    exu_pkg::data_t    iss_rs1;
    exu_pkg::data_t    iss_rs2;
    exu_pkg::rob_idx_t iss_rob;
    logic              iss_epoch;
    logic              iss_pred_taken;

    // result side and returned slots.
    logic              res_valid;
    exu_pkg::rob_idx_t res_rob;
    exu_pkg::data_t    res_data;
    logic              buf_credit;
    logic              sq_credit;

    issue_queue #(
        .iq_depth  (iq_depth),
        .buf_depth (buf_depth)
    ) i_issue_queue (
        .clk             (clk),
        .rst             (rst),
        .disp_valid      (disp_valid),
        .disp_op         (disp_op),
        .disp_rs1        (disp_rs1),
        .disp_rs2        (disp_rs2),
        .disp_rob        (disp_rob),
        .disp_epoch      (disp_epoch),
        .disp_pred_taken (disp_pred_taken),
        .disp_credit     (disp_credit),
        .iss_valid       (iss_valid),
        .iss_op          (iss_op),
        .iss_rs1         (iss_rs1),
        .iss_rs2         (iss_rs2),
        .iss_rob         (iss_rob),
        .iss_epoch       (iss_epoch),
        .iss_pred_taken  (iss_pred_taken),
        .buf_credit      (buf_credit),
        .sq_credit       (sq_credit)
    );

    alu_unit i_alu_unit (
        .clk            (clk),
        .rst            (rst),
        .iss_valid      (iss_valid),
        .iss_op         (iss_op),
        .iss_rs1        (iss_rs1),
        .iss_rs2        (iss_rs2),
        .iss_rob        (iss_rob),
        .iss_epoch      (iss_epoch),
        .iss_pred_taken (iss_pred_taken),
        .res_valid      (res_valid),
        .res_rob        (res_rob),
        .res_data       (res_data),
        .sq_credit      (sq_credit),
        .redirect_valid (redirect_valid),
        .redirect_rob   (redirect_rob),
        .redirect_taken (redirect_taken)
    );

    result_buffer #(
        .buf_depth  (buf_depth),
        .wb_credits (wb_credits)
    ) i_result_buffer (
        .clk        (clk),
        .rst        (rst),
        .res_valid  (res_valid),
        .res_rob    (res_rob),
        .res_data   (res_data),
        .buf_credit (buf_credit),
        .wb_valid   (wb_valid),
        .wb_rob     (wb_rob),
        .wb_data    (wb_data),
        .wb_credit  (wb_credit)
    );

endmodule

// File: verilog/issue_queue.sv
`timescale 1ns/1ps

module issue_queue #(
    parameter int iq_depth  = 4,
    parameter int buf_depth = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              disp_valid,
    input  exu_pkg::alu_op_t  disp_op,
    input  exu_pkg::data_t    disp_rs1,
    input  exu_pkg::data_t    disp_rs2,
    input  exu_pkg::rob_idx_t disp_rob,
    input  logic              disp_epoch,
    input  logic              disp_pred_taken,
    output logic              disp_credit,
    output logic              iss_valid,
    output exu_pkg::alu_op_t  iss_op,
    output exu_pkg::data_t    iss_rs1,
    output exu_pkg::data_t    iss_rs2,
    output exu_pkg::rob_idx_t iss_rob,
    output logic              iss_epoch,
    output logic              iss_pred_taken,
    input  logic              buf_credit,
    input  logic              sq_credit
);
    localparam int ptr_w   = (iq_depth > 1) ? $clog2(iq_depth) : 1;
    localparam int cnt_w   = $clog2(iq_depth + 1);
    localparam int space_w = $clog2(buf_depth + 1);

    exu_pkg::alu_op_t  op_q    [iq_depth];
    exu_pkg::data_t    rs1_q   [iq_depth];
    exu_pkg::data_t    rs2_q   [iq_depth];
    exu_pkg::rob_idx_t rob_q   [iq_depth];
    logic              epoch_q [iq_depth];
    logic              pred_q  [iq_depth];

    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic [space_w-1:0] space_cnt;
    logic               issue;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        logic [ptr_w-1:0] n;
        n = (p == ptr_w'(iq_depth - 1)) ? '0 : p + 1'b1;
        return n;
    endfunction

    // head goes out while a result-buffer slot can be reserved.
    assign issue          = (count != '0) && (space_cnt != '0);
    assign iss_valid      = issue;
    assign iss_op         = op_q[rd_ptr];
    assign iss_rs1        = rs1_q[rd_ptr];
    assign iss_rs2        = rs2_q[rd_ptr];
    assign iss_rob        = rob_q[rd_ptr];
    assign iss_epoch      = epoch_q[rd_ptr];
    assign iss_pred_taken = pred_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (disp_valid) begin
            op_q[wr_ptr]    <= disp_op;
            rs1_q[wr_ptr]   <= disp_rs1;
            rs2_q[wr_ptr]   <= disp_rs2;
            rob_q[wr_ptr]   <= disp_rob;
            epoch_q[wr_ptr] <= disp_epoch;
            pred_q[wr_ptr]  <= disp_pred_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            disp_credit <= 1'b0;
            space_cnt   <= space_w'(buf_depth);
        end else begin
            if (disp_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count       <= count + cnt_w'(disp_valid) - cnt_w'(issue);
            disp_credit <= issue;
            // slots come back on a pop or a squash.
            space_cnt   <= space_cnt - space_w'(issue)
                         + space_w'(buf_credit) + space_w'(sq_credit);
        end
    end

endmodule

// File: verilog/result_buffer.sv
`timescale 1ns/1ps

module result_buffer #(
    parameter int buf_depth  = 4,
    parameter int wb_credits = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              res_valid,
    input  exu_pkg::rob_idx_t res_rob,
    input  exu_pkg::data_t    res_data,
    output logic              buf_credit,
    output logic              wb_valid,
    output exu_pkg::rob_idx_t wb_rob,
    output exu_pkg::data_t    wb_data,
    input  logic              wb_credit
);
    localparam int ptr_w  = (buf_depth > 1) ? $clog2(buf_depth) : 1;
    localparam int cnt_w  = $clog2(buf_depth + 1);
    localparam int cred_w = $clog2(wb_credits + 1);

    exu_pkg::rob_idx_t rob_q  [buf_depth];
    exu_pkg::data_t    data_q [buf_depth];

    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic [cred_w-1:0] wb_cnt;
    logic              pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        logic [ptr_w-1:0] n;
        n = (p == ptr_w'(buf_depth - 1)) ? '0 : p + 1'b1;
        return n;
    endfunction

    // drains only while the consumer has room.
    assign pop      = (count != '0) && (wb_cnt != '0);
    assign wb_valid = pop;
    assign wb_rob   = rob_q[rd_ptr];
    assign wb_data  = data_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (res_valid) begin
            rob_q[wr_ptr]  <= res_rob;
            data_q[wr_ptr] <= res_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            buf_credit <= 1'b0;
            wb_cnt     <= cred_w'(wb_credits);
        end else begin
            if (res_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count      <= count + cnt_w'(res_valid) - cnt_w'(pop);
            buf_credit <= pop;
            wb_cnt     <= wb_cnt - cred_w'(pop) + cred_w'(wb_credit);
        end
    end

endmodule
